//--- rtl/mips_pkg.sv
package mips_pkg;

	localparam int word_width = 32;
	localparam int register_address_width = 5;
	localparam int memory_depth = 256;
	localparam int memory_address_width = 8;
	localparam int alu_op_width = 4;

	// Major opcodes
	localparam logic [5:0] opcode_rtype = 6'b000000;
	localparam logic [5:0] opcode_addiu = 6'b001001;
	localparam logic [5:0] opcode_slti = 6'b001010;
	localparam logic [5:0] opcode_ori = 6'b001101;
	localparam logic [5:0] opcode_xori = 6'b001110;
	localparam logic [5:0] opcode_lui = 6'b001111;

	// R-type function field
	localparam logic [5:0] funct_addu = 6'b100001;
	localparam logic [5:0] funct_subu = 6'b100011;
	localparam logic [5:0] funct_and = 6'b100100;
	localparam logic [5:0] funct_or = 6'b100101;
	localparam logic [5:0] funct_xor = 6'b100110;
	localparam logic [5:0] funct_nor = 6'b100111;
	localparam logic [5:0] funct_slt = 6'b101010;
	localparam logic [5:0] funct_sltu = 6'b101011;
	localparam logic [5:0] funct_sll = 6'b000000;
	localparam logic [5:0] funct_srl = 6'b000010;
	localparam logic [5:0] funct_sra = 6'b000011;

	localparam logic [alu_op_width-1:0] alu_add = 4'd0;
	localparam logic [alu_op_width-1:0] alu_sub = 4'd1;
	localparam logic [alu_op_width-1:0] alu_and = 4'd2;
	localparam logic [alu_op_width-1:0] alu_or = 4'd3;
	localparam logic [alu_op_width-1:0] alu_xor = 4'd4;
	localparam logic [alu_op_width-1:0] alu_nor = 4'd5;
	localparam logic [alu_op_width-1:0] alu_slt = 4'd6;
	localparam logic [alu_op_width-1:0] alu_sltu = 4'd7;
	localparam logic [alu_op_width-1:0] alu_sll = 4'd8;
	localparam logic [alu_op_width-1:0] alu_srl = 4'd9;
	localparam logic [alu_op_width-1:0] alu_sra = 4'd10;
	localparam logic [alu_op_width-1:0] alu_lui = 4'd11;
	localparam logic [alu_op_width-1:0] alu_none = 4'd15; // Result forced to zero

	// One instruction word, seen as R-type or I-type fields
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [register_address_width-1:0] rs;
			logic [register_address_width-1:0] rt;
			logic [register_address_width-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [register_address_width-1:0] rs;
			logic [register_address_width-1:0] rt;
			logic [15:0] immediate;
		} i;
	} instruction_word_t;

endpackage

//--- rtl/program_memory.sv
`timescale 1ns/1ps

module program_memory (
	input logic clock,
	input logic load_enable,
	input logic [mips_pkg::memory_address_width-1:0] load_address,
	input logic [mips_pkg::word_width-1:0] load_data,
	input logic [mips_pkg::memory_address_width-1:0] fetch_address,
	output logic [mips_pkg::word_width-1:0] instruction
);

	logic [mips_pkg::word_width-1:0] memory [mips_pkg::memory_depth];

	// Program load port
	always_ff @(posedge clock) begin
		if (load_enable) begin
			memory[load_address] <= load_data;
		end
	end

	// Fetch port, one cycle latency
	always_ff @(posedge clock) begin
		instruction <= memory[fetch_address];
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input logic clock,
	input logic reset,
	input logic run,
	output logic [mips_pkg::memory_address_width-1:0] fetch_address,
	output logic fetch_valid,
	output logic [mips_pkg::word_width-1:0] fetch_pc
);

	logic [mips_pkg::word_width-1:0] pc; // Byte address

	// Word index into program memory
	assign fetch_address = pc[mips_pkg::memory_address_width+1:2];

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= run;
			if (run) begin
				pc <= pc + 32'd4;
			end
		end
	end

	// Lines up with the registered memory output
	always_ff @(posedge clock) begin
		if (run) begin
			fetch_pc <= pc;
		end
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input logic clock,
	input logic reset,
	input logic [mips_pkg::register_address_width-1:0] read_address_a,
	input logic [mips_pkg::register_address_width-1:0] read_address_b,
	input logic write_enable,
	input logic [mips_pkg::register_address_width-1:0] write_address,
	input logic [mips_pkg::word_width-1:0] write_data,
	output logic [mips_pkg::word_width-1:0] read_data_a,
	output logic [mips_pkg::word_width-1:0] read_data_b
);

	logic [mips_pkg::word_width-1:0] registers [2**mips_pkg::register_address_width];

	// Write-through covers a producer two instructions ahead
	function automatic logic [mips_pkg::word_width-1:0] read_port(
		input logic [mips_pkg::register_address_width-1:0] address
	);
		if (address == '0)
			return '0;
		else if (write_enable && address == write_address)
			return write_data;
		else
			return registers[address];
	endfunction

	always_comb begin
		read_data_a = read_port(read_address_a);
		read_data_b = read_port(read_address_b);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int index = 0; index < 2**mips_pkg::register_address_width; index++) begin
				registers[index] <= '0;
			end
		end else if (write_enable && write_address != '0) begin // r0 stays zero
			registers[write_address] <= write_data;
		end
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input logic [mips_pkg::word_width-1:0] fetch_pc,
	input mips_pkg::instruction_word_t instruction,
	input logic [mips_pkg::word_width-1:0] read_data_a,
	input logic [mips_pkg::word_width-1:0] read_data_b,
	output logic [mips_pkg::register_address_width-1:0] read_address_a,
	output logic [mips_pkg::register_address_width-1:0] read_address_b,
	output logic decode_valid,
	output logic [mips_pkg::word_width-1:0] decode_pc,
	output logic [mips_pkg::alu_op_width-1:0] alu_op,
	output logic [mips_pkg::word_width-1:0] operand_a,
	output logic [mips_pkg::word_width-1:0] operand_b,
	output logic [4:0] shift_amount,
	output logic [mips_pkg::register_address_width-1:0] destination,
	output logic [mips_pkg::register_address_width-1:0] rs_index,
	output logic [mips_pkg::register_address_width-1:0] rt_index,
	output logic uses_rt
);

	logic [mips_pkg::alu_op_width-1:0] next_alu_op;
	logic [mips_pkg::word_width-1:0] next_operand_b;
	logic [mips_pkg::register_address_width-1:0] next_destination;
	logic next_uses_rt;
	logic [mips_pkg::word_width-1:0] sign_immediate;
	logic [mips_pkg::word_width-1:0] zero_immediate;

	assign read_address_a = instruction.r.rs;
	assign read_address_b = instruction.r.rt;

	assign sign_immediate = {{16{instruction.i.immediate[15]}}, instruction.i.immediate};
	assign zero_immediate = {16'b0, instruction.i.immediate};

	always_comb begin
		next_alu_op = mips_pkg::alu_none;
		next_operand_b = read_data_b; // rt value, also the shift source
		next_destination = '0;
		next_uses_rt = 1'b0;
		case (instruction.i.opcode)
			mips_pkg::opcode_rtype: begin
				case (instruction.r.funct)
					mips_pkg::funct_addu: next_alu_op = mips_pkg::alu_add;
					mips_pkg::funct_subu: next_alu_op = mips_pkg::alu_sub;
					mips_pkg::funct_and: next_alu_op = mips_pkg::alu_and;
					mips_pkg::funct_or: next_alu_op = mips_pkg::alu_or;
					mips_pkg::funct_xor: next_alu_op = mips_pkg::alu_xor;
					mips_pkg::funct_nor: next_alu_op = mips_pkg::alu_nor;
					mips_pkg::funct_slt: next_alu_op = mips_pkg::alu_slt;
					mips_pkg::funct_sltu: next_alu_op = mips_pkg::alu_sltu;
					mips_pkg::funct_sll: next_alu_op = mips_pkg::alu_sll;
					mips_pkg::funct_srl: next_alu_op = mips_pkg::alu_srl;
					mips_pkg::funct_sra: next_alu_op = mips_pkg::alu_sra;
					default: next_alu_op = mips_pkg::alu_none;
				endcase
				if (next_alu_op != mips_pkg::alu_none) begin
					next_destination = instruction.r.rd;
					next_uses_rt = 1'b1;
				end
			end
			mips_pkg::opcode_addiu: begin
				next_alu_op = mips_pkg::alu_add;
				next_operand_b = sign_immediate;
				next_destination = instruction.i.rt;
			end
			mips_pkg::opcode_slti: begin
				next_alu_op = mips_pkg::alu_slt;
				next_operand_b = sign_immediate;
				next_destination = instruction.i.rt;
			end
			mips_pkg::opcode_ori: begin
				next_alu_op = mips_pkg::alu_or;
				next_operand_b = zero_immediate;
				next_destination = instruction.i.rt;
			end
			mips_pkg::opcode_xori: begin
				next_alu_op = mips_pkg::alu_xor;
				next_operand_b = zero_immediate;
				next_destination = instruction.i.rt;
			end
			mips_pkg::opcode_lui: begin
				next_alu_op = mips_pkg::alu_lui;
				next_operand_b = zero_immediate;
				next_destination = instruction.i.rt;
			end
			default: next_alu_op = mips_pkg::alu_none; // Retires as r0 with zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			decode_valid <= 1'b0;
		else
			decode_valid <= fetch_valid;
	end

	always_ff @(posedge clock) begin
		decode_pc <= fetch_pc;
		alu_op <= next_alu_op;
		operand_a <= read_data_a;
		operand_b <= next_operand_b;
		shift_amount <= instruction.r.shamt;
		destination <= next_destination;
		rs_index <= instruction.r.rs;
		rt_index <= instruction.r.rt;
		uses_rt <= next_uses_rt;
	end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input logic [mips_pkg::word_width-1:0] decode_pc,
	input logic [mips_pkg::alu_op_width-1:0] alu_op,
	input logic [mips_pkg::word_width-1:0] operand_a,
	input logic [mips_pkg::word_width-1:0] operand_b,
	input logic [4:0] shift_amount,
	input logic [mips_pkg::register_address_width-1:0] destination,
	input logic [mips_pkg::register_address_width-1:0] rs_index,
	input logic [mips_pkg::register_address_width-1:0] rt_index,
	input logic uses_rt,
	output logic result_valid,
	output logic [mips_pkg::word_width-1:0] result_pc,
	output logic [mips_pkg::register_address_width-1:0] result_register,
	output logic [mips_pkg::word_width-1:0] result_data,
	output logic write_enable,
	output logic [mips_pkg::register_address_width-1:0] write_address,
	output logic [mips_pkg::word_width-1:0] write_data
);

	logic forward_a;
	logic forward_b;
	logic [mips_pkg::word_width-1:0] source_a;
	logic [mips_pkg::word_width-1:0] source_b;
	logic [mips_pkg::word_width-1:0] alu_result;

	// Bypass from the instruction one ahead
	assign forward_a = result_valid && result_register != '0 && result_register == rs_index;
	assign forward_b = result_valid && uses_rt && result_register != '0
		&& result_register == rt_index;

	assign source_a = forward_a ? result_data : operand_a;
	assign source_b = forward_b ? result_data : operand_b;

	always_comb begin
		case (alu_op)
			mips_pkg::alu_add: alu_result = source_a + source_b;
			mips_pkg::alu_sub: alu_result = source_a - source_b;
			mips_pkg::alu_and: alu_result = source_a & source_b;
			mips_pkg::alu_or: alu_result = source_a | source_b;
			mips_pkg::alu_xor: alu_result = source_a ^ source_b;
			mips_pkg::alu_nor: alu_result = ~(source_a | source_b);
			mips_pkg::alu_slt: begin
				alu_result = {31'b0, $signed(source_a) < $signed(source_b)};
			end
			mips_pkg::alu_sltu: alu_result = {31'b0, source_a < source_b};
			mips_pkg::alu_sll: alu_result = source_b << shift_amount;
			mips_pkg::alu_srl: alu_result = source_b >> shift_amount;
			mips_pkg::alu_sra: alu_result = $signed(source_b) >>> shift_amount;
			mips_pkg::alu_lui: alu_result = {source_b[15:0], 16'b0};
			default: alu_result = '0; // alu_none and unused codes
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= decode_valid;
	end

	always_ff @(posedge clock) begin
		result_pc <= decode_pc;
		result_register <= destination;
		result_data <= alu_result;
	end

	// Register file writes on the next edge
	assign write_enable = result_valid;
	assign write_address = result_register;
	assign write_data = result_data;

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input logic clock,
	input logic reset,
	input logic run,
	input logic load_enable,
	input logic [mips_pkg::memory_address_width-1:0] load_address,
	input logic [mips_pkg::word_width-1:0] load_data,
	output logic result_valid,
	output logic [mips_pkg::word_width-1:0] result_pc,
	output logic [mips_pkg::register_address_width-1:0] result_register,
	output logic [mips_pkg::word_width-1:0] result_data
);

	logic [mips_pkg::memory_address_width-1:0] fetch_address;
	logic fetch_valid;
	logic [mips_pkg::word_width-1:0] fetch_pc;
	mips_pkg::instruction_word_t instruction;

	logic [mips_pkg::register_address_width-1:0] read_address_a;
	logic [mips_pkg::register_address_width-1:0] read_address_b;
	logic [mips_pkg::word_width-1:0] read_data_a;
	logic [mips_pkg::word_width-1:0] read_data_b;

	logic decode_valid;
	logic [mips_pkg::word_width-1:0] decode_pc;
	logic [mips_pkg::alu_op_width-1:0] alu_op;
	logic [mips_pkg::word_width-1:0] operand_a;
	logic [mips_pkg::word_width-1:0] operand_b;
	logic [4:0] shift_amount;
	logic [mips_pkg::register_address_width-1:0] destination;
	logic [mips_pkg::register_address_width-1:0] rs_index;
	logic [mips_pkg::register_address_width-1:0] rt_index;
	logic uses_rt;

	logic write_enable;
	logic [mips_pkg::register_address_width-1:0] write_address;
	logic [mips_pkg::word_width-1:0] write_data;

	program_memory memory (
		.clock (clock),
		.load_enable (load_enable),
		.load_address (load_address),
		.load_data (load_data),
		.fetch_address (fetch_address),
		.instruction (instruction)
	);

	fetch_unit fetch (
		.clock (clock),
		.reset (reset),
		.run (run),
		.fetch_address (fetch_address),
		.fetch_valid (fetch_valid),
		.fetch_pc (fetch_pc)
	);

	register_file registers (
		.clock (clock),
		.reset (reset),
		.read_address_a (read_address_a),
		.read_address_b (read_address_b),
		.write_enable (write_enable),
		.write_address (write_address),
		.write_data (write_data),
		.read_data_a (read_data_a),
		.read_data_b (read_data_b)
	);

	decode_stage decode (
		.clock (clock),
		.reset (reset),
		.fetch_valid (fetch_valid),
		.fetch_pc (fetch_pc),
		.instruction (instruction),
		.read_data_a (read_data_a),
		.read_data_b (read_data_b),
		.read_address_a (read_address_a),
		.read_address_b (read_address_b),
		.decode_valid (decode_valid),
		.decode_pc (decode_pc),
		.alu_op (alu_op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.shift_amount (shift_amount),
		.destination (destination),
		.rs_index (rs_index),
		.rt_index (rt_index),
		.uses_rt (uses_rt)
	);

	execute_stage execute (
		.clock (clock),
		.reset (reset),
		.decode_valid (decode_valid),
		.decode_pc (decode_pc),
		.alu_op (alu_op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.shift_amount (shift_amount),
		.destination (destination),
		.rs_index (rs_index),
		.rt_index (rt_index),
		.uses_rt (uses_rt),
		.result_valid (result_valid),
		.result_pc (result_pc),
		.result_register (result_register),
		.result_data (result_data),
		.write_enable (write_enable),
		.write_address (write_address),
		.write_data (write_data)
	);

endmodule

//--- verification/mips_core_assert.sv
`timescale 1ns/1ps

module mips_core_assert (
	input logic clock,
	input logic reset,
	input logic run,
	input logic result_valid,
	input logic [mips_pkg::word_width-1:0] result_pc
);

	// Pipeline is empty right after reset
	reset_clears_retire: assert property (@(posedge clock) reset |=> !result_valid)
		else $error("result_valid high in the cycle after reset");

	pc_steps_by_four: assert property (@(posedge clock) disable iff (reset)
		result_valid && $past(result_valid) |-> result_pc == $past(result_pc) + 32'd4)
		else $error("result_pc did not advance by 4 between back to back retirements");

	valid_is_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(result_valid))
		else $error("result_valid is unknown");

	// Two instructions in flight drain within three cycles of run going low
	drained_after_stop: assert property (@(posedge clock) disable iff (reset)
		!$past(run, 1) && !$past(run, 2) && !$past(run, 3) |-> !result_valid)
		else $error("result_valid high more than 3 cycles after run went low");

endmodule

//--- verification/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

	localparam int reset_cycles = 5;
	localparam int retire_timeout = 20; // Idle cycles allowed between retirements
	localparam int drain_cycles = 4;
	localparam logic [31:0] nop_word = 32'h0000_0000; // sll r0, r0, 0

	logic clock;
	logic reset;
	logic run;
	logic load_enable;
	logic [mips_pkg::memory_address_width-1:0] load_address;
	logic [mips_pkg::word_width-1:0] load_data;
	logic result_valid;
	logic [mips_pkg::word_width-1:0] result_pc;
	logic [mips_pkg::register_address_width-1:0] result_register;
	logic [mips_pkg::word_width-1:0] result_data;

	logic [31:0] lcg_state;
	logic [31:0] model_registers [32];
	logic [31:0] program_words [$];
	logic [31:0] expected_pc [$];
	logic [4:0] expected_register [$];
	logic [31:0] expected_data [$];

	mips_core dut (
		.clock (clock),
		.reset (reset),
		.run (run),
		.load_enable (load_enable),
		.load_address (load_address),
		.load_data (load_data),
		.result_valid (result_valid),
		.result_pc (result_pc),
		.result_register (result_register),
		.result_data (result_data)
	);

	bind mips_core mips_core_assert protocol_checks (
		.clock (clock),
		.reset (reset),
		.run (run),
		.result_valid (result_valid),
		.result_pc (result_pc)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {mips_pkg::opcode_rtype, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] opcode, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] immediate);
		return {opcode, rs, rt, immediate};
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
			stop_on_failure("A DUT output did not match the reference model");
		end
	endtask

	// Reference model of one instruction, straight from the ISA rules
	task automatic predict_retirement(input logic [31:0] word, input int index);
		logic [31:0] value_a;
		logic [31:0] value_b;
		logic [31:0] sign_immediate;
		logic [31:0] zero_immediate;
		logic [31:0] value;
		logic [4:0] target;
		value_a = model_registers[word[25:21]];
		value_b = model_registers[word[20:16]];
		sign_immediate = {{16{word[15]}}, word[15:0]};
		zero_immediate = {16'h0000, word[15:0]};
		value = 32'd0;
		target = word[20:16];
		if (word[31:26] == mips_pkg::opcode_rtype) begin
			target = word[15:11];
			case (word[5:0])
				mips_pkg::funct_addu: value = value_a + value_b;
				mips_pkg::funct_subu: value = value_a - value_b;
				mips_pkg::funct_and: value = value_a & value_b;
				mips_pkg::funct_or: value = value_a | value_b;
				mips_pkg::funct_xor: value = value_a ^ value_b;
				mips_pkg::funct_nor: value = ~(value_a | value_b);
				mips_pkg::funct_slt: value = ($signed(value_a) < $signed(value_b)) ? 32'd1 : 32'd0;
				mips_pkg::funct_sltu: value = (value_a < value_b) ? 32'd1 : 32'd0;
				mips_pkg::funct_sll: value = value_b << word[10:6];
				mips_pkg::funct_srl: value = value_b >> word[10:6];
				mips_pkg::funct_sra: value = $signed(value_b) >>> word[10:6];
				default: target = 5'd0;
			endcase
		end else begin
			case (word[31:26])
				mips_pkg::opcode_addiu: value = value_a + sign_immediate;
				mips_pkg::opcode_slti: begin
					value = ($signed(value_a) < $signed(sign_immediate)) ? 32'd1 : 32'd0;
				end
				mips_pkg::opcode_ori: value = value_a | zero_immediate;
				mips_pkg::opcode_xori: value = value_a ^ zero_immediate;
				mips_pkg::opcode_lui: value = {word[15:0], 16'h0000};
				default: target = 5'd0; // Dropped opcodes retire as r0 with zero
			endcase
		end
		if (target != 5'd0)
			model_registers[target] = value;
		expected_pc.push_back(index * 4);
		expected_register.push_back(target);
		expected_data.push_back(value);
	endtask

	task automatic reset_dut();
		@(negedge clock);
		reset = 1'b1;
		run = 1'b0;
		load_enable = 1'b0;
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		for (int index = 0; index < 32; index++)
			model_registers[index] = 32'd0;
	endtask

	task automatic load_program();
		for (int address = 0; address < mips_pkg::memory_depth; address++) begin
			@(negedge clock);
			load_enable = 1'b1;
			load_address = address[mips_pkg::memory_address_width-1:0];
			load_data = (address < program_words.size()) ? program_words[address] : nop_word;
		end
		@(negedge clock);
		load_enable = 1'b0;
	endtask

	// Runs exactly count fetches, then checks every retirement and the drain
	task automatic run_and_collect(input int count);
		int fetched;
		int retired;
		int retired_at_stop;
		int idle;
		expected_pc.delete();
		expected_register.delete();
		expected_data.delete();
		for (int index = 0; index < count; index++)
			predict_retirement(program_words[index], index);
		fetched = 0;
		retired = 0;
		retired_at_stop = 0;
		idle = 0;
		run = 1'b1;
		while (retired < count) begin
			@(negedge clock);
			if (run)
				fetched++;
			if (result_valid) begin
				check_value("result_pc", result_pc, expected_pc[retired]);
				check_value("result_register", {27'd0, result_register},
					{27'd0, expected_register[retired]});
				check_value("result_data", result_data, expected_data[retired]);
				// Consecutive instructions retire on consecutive cycles
				if (retired > 0)
					check_value("idle cycles between retirements", idle, 32'd0);
				retired++;
				idle = 0;
			end else begin
				idle++;
				if (idle > retire_timeout)
					stop_on_failure("Timed out waiting for an instruction to retire");
			end
			if (run && fetched == count) begin
				run = 1'b0;
				retired_at_stop = retired;
			end
		end
		check_value("retirements after run dropped", retired - retired_at_stop, 32'd2);
		repeat (drain_cycles) begin
			@(negedge clock);
			if (result_valid)
				stop_on_failure("An extra instruction retired after the pipeline drained");
		end
	endtask

	task automatic execute_program(input int count);
		reset_dut();
		load_program();
		run_and_collect(count);
	endtask

	task automatic test_logic_operations();
		program_words.delete();
		program_words.push_back(encode_i(mips_pkg::opcode_lui, 5'd0, 5'd1, 16'h1234));
		program_words.push_back(encode_i(mips_pkg::opcode_lui, 5'd0, 5'd2, 16'hF0F0));
		program_words.push_back(encode_i(mips_pkg::opcode_lui, 5'd0, 5'd3, 16'h8000));
		program_words.push_back(encode_i(mips_pkg::opcode_ori, 5'd1, 5'd1, 16'h5678));
		program_words.push_back(encode_i(mips_pkg::opcode_ori, 5'd2, 5'd2, 16'h0FF0));
		program_words.push_back(encode_i(mips_pkg::opcode_ori, 5'd3, 5'd3, 16'h00FF));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd7, 16'h0011));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd1, 5'd2, 5'd4, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_subu, 5'd1, 5'd3, 5'd5, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_and, 5'd2, 5'd3, 5'd6, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_or, 5'd1, 5'd3, 5'd8, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_xor, 5'd2, 5'd7, 5'd9, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_nor, 5'd4, 5'd5, 5'd10, 5'd0));
		execute_program(program_words.size());
	endtask

	task automatic test_immediates();
		program_words.delete();
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd1, 16'hFFF6));
		program_words.push_back(encode_i(mips_pkg::opcode_ori, 5'd0, 5'd2, 16'h8001));
		program_words.push_back(encode_i(mips_pkg::opcode_xori, 5'd0, 5'd3, 16'hF00F));
		program_words.push_back(encode_i(mips_pkg::opcode_lui, 5'd0, 5'd4, 16'hABCD));
		program_words.push_back(encode_i(mips_pkg::opcode_slti, 5'd1, 5'd5, 16'hFFFB));
		program_words.push_back(encode_i(mips_pkg::opcode_slti, 5'd0, 5'd6, 16'hFFFF));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd4, 5'd7, 16'h8000));
		program_words.push_back(encode_i(mips_pkg::opcode_xori, 5'd2, 5'd8, 16'h8000));
		execute_program(program_words.size());
	endtask

	task automatic test_shifts_compares();
		program_words.delete();
		program_words.push_back(encode_i(mips_pkg::opcode_lui, 5'd0, 5'd1, 16'h8000));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd2, 16'h0001));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd3, 16'hFFFF));
		program_words.push_back(encode_i(mips_pkg::opcode_ori, 5'd1, 5'd1, 16'h00F0));
		program_words.push_back(encode_r(mips_pkg::funct_sll, 5'd0, 5'd3, 5'd4, 5'd4));
		program_words.push_back(encode_r(mips_pkg::funct_srl, 5'd0, 5'd1, 5'd5, 5'd8));
		program_words.push_back(encode_r(mips_pkg::funct_sra, 5'd0, 5'd1, 5'd6, 5'd8));
		program_words.push_back(encode_r(mips_pkg::funct_slt, 5'd1, 5'd2, 5'd7, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_sltu, 5'd1, 5'd2, 5'd8, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_slt, 5'd2, 5'd3, 5'd9, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_sltu, 5'd2, 5'd3, 5'd10, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_sra, 5'd0, 5'd3, 5'd11, 5'd31));
		program_words.push_back(encode_r(mips_pkg::funct_srl, 5'd0, 5'd3, 5'd12, 5'd31));
		execute_program(program_words.size());
	endtask

	task automatic test_forwarding();
		program_words.delete();
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd1, 16'h0005));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd1, 5'd2, 16'h0003));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd2, 5'd1, 5'd3, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_subu, 5'd3, 5'd1, 5'd4, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_xor, 5'd1, 5'd4, 5'd5, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd3, 5'd5, 5'd6, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_or, 5'd6, 5'd6, 5'd7, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_sll, 5'd0, 5'd7, 5'd8, 5'd2));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd1, 5'd1, 16'h0001));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd1, 5'd1, 16'h0001));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd1, 5'd8, 5'd9, 5'd0));
		execute_program(program_words.size());
	endtask

	task automatic test_zero_register();
		program_words.delete();
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd0, 16'h1234));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd0, 5'd0, 5'd1, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_or, 5'd0, 5'd0, 5'd2, 5'd0));
		program_words.push_back(encode_i(mips_pkg::opcode_addiu, 5'd0, 5'd3, 16'h0007));
		program_words.push_back(encode_i(6'b100011, 5'd1, 5'd5, 16'h0004)); // lw
		program_words.push_back(encode_r(6'b011000, 5'd3, 5'd3, 5'd6, 5'd0)); // mult
		program_words.push_back(encode_i(6'b001000, 5'd3, 5'd6, 16'h0001)); // addi
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd3, 5'd0, 5'd7, 5'd0));
		program_words.push_back(encode_r(mips_pkg::funct_addu, 5'd5, 5'd6, 5'd8, 5'd0));
		execute_program(program_words.size());
	endtask

	function automatic logic [31:0] random_instruction();
		logic [31:0] fields;
		logic [31:0] choice;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		fields = next_random();
		choice = next_random();
		rs = {2'b00, fields[31:29]}; // Few registers, so dependencies are frequent
		rt = {2'b00, fields[28:26]};
		rd = {2'b00, fields[25:23]};
		case (choice[31:28])
			4'd0: return encode_r(mips_pkg::funct_addu, rs, rt, rd, 5'd0);
			4'd1: return encode_r(mips_pkg::funct_subu, rs, rt, rd, 5'd0);
			4'd2: return encode_r(mips_pkg::funct_and, rs, rt, rd, 5'd0);
			4'd3: return encode_r(mips_pkg::funct_or, rs, rt, rd, 5'd0);
			4'd4: return encode_r(mips_pkg::funct_xor, rs, rt, rd, 5'd0);
			4'd5: return encode_r(mips_pkg::funct_nor, rs, rt, rd, 5'd0);
			4'd6: return encode_r(mips_pkg::funct_slt, rs, rt, rd, 5'd0);
			4'd7: return encode_r(mips_pkg::funct_sltu, rs, rt, rd, 5'd0);
			4'd8: return encode_r(mips_pkg::funct_sll, 5'd0, rt, rd, fields[4:0]);
			4'd9: return encode_r(mips_pkg::funct_srl, 5'd0, rt, rd, fields[4:0]);
			4'd10: return encode_r(mips_pkg::funct_sra, 5'd0, rt, rd, fields[4:0]);
			4'd11: return encode_i(mips_pkg::opcode_addiu, rs, rt, fields[15:0]);
			4'd12: return encode_i(mips_pkg::opcode_slti, rs, rt, fields[15:0]);
			4'd13: return encode_i(mips_pkg::opcode_ori, rs, rt, fields[15:0]);
			4'd14: return encode_i(mips_pkg::opcode_xori, rs, rt, fields[15:0]);
			default: return encode_i(mips_pkg::opcode_lui, 5'd0, rt, fields[15:0]);
		endcase
	endfunction

	task automatic test_random_programs();
		logic [31:0] value;
		int length;
		int count;
		for (int program_index = 0; program_index < 5; program_index++) begin
			value = next_random();
			length = 12 + int'(value[31:28]);
			count = length - int'(value[27:26]); // Run may stop before the last words
			program_words.delete();
			for (int index = 0; index < length; index++)
				program_words.push_back(random_instruction());
			execute_program(count);
		end
	endtask

	initial begin
		lcg_state = 32'd14;
		reset = 1'b1;
		run = 1'b0;
		load_enable = 1'b0;
		load_address = '0;
		load_data = '0;
		test_logic_operations();
		test_immediates();
		test_shifts_compares();
		test_forwarding();
		test_zero_register();
		test_random_programs();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- all.f
rtl/mips_pkg.sv
rtl/program_memory.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mips_core.sv
verification/mips_core_assert.sv
verification/mips_core_tb.sv

//--- Makefile
# Verilator flow for the MIPS pipeline testbench

VERILATOR ?= verilator
TOP ?= mips_core_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# A failing check ends in $$fatal, so the exit status carries the result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
